// File: ctcq.f
hw/ctcq_pkg.sv
hw/ctcq_entry.sv
hw/ctcq_create_ctrl.sv
hw/ctcq_issue_arb.sv
hw/ctcq_inv_engine.sv
hw/ctcq_top.sv
sim/ctcq_checker.sv
sim/ctcq_tb.sv

// File: hw/ctcq_create_ctrl.sv
// ctcq creation and retire control
`timescale 1ns/1ns
`default_nettype none

module ctcq_create_ctrl #(
  parameter  int NUM_ENTRY = 4,
  localparam int IDX_W     = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1
) (
  input  logic                 ctcqctrlclk,
  input  logic                 cpurst_b,
  input  logic                 trans_vld,
  input  logic                 trans_first,
  input  logic [NUM_ENTRY-1:0] entry_vld,
  input  logic [NUM_ENTRY-1:0] wait_2nd,
  input  logic [NUM_ENTRY-1:0] cmplt_x,
  input  logic [NUM_ENTRY-1:0] cmplt_2,
  output logic                 trans_rdy,
  output logic [NUM_ENTRY-1:0] create_en,
  output logic [NUM_ENTRY-1:0] inv_en,
  output logic                 resp_vld
);

  // circular index step
  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    return (idx == IDX_W'(NUM_ENTRY - 1)) ? '0 : idx + 1'b1;
  endfunction

  //******************************
  // pointers
  //******************************
  logic [IDX_W-1:0] alloc_ptr;
  logic [IDX_W-1:0] retire_ptr;
  // last allocated entry, home of any second transaction
  logic [IDX_W-1:0] pend_idx;
  logic             pend_2nd;
  logic             entry_free;
  logic             accept;
  logic             retire_en;
  logic             retire_last;

  // second pending until that entry has its va/pa
  assign pend_2nd   = wait_2nd[pend_idx];
  // age order, so the slot at alloc_ptr is the only candidate
  assign entry_free = !entry_vld[alloc_ptr];

  assign trans_rdy = trans_first ? (entry_free && !pend_2nd) : pend_2nd;
  assign accept    = trans_vld && trans_rdy;

  // steer create to new slot or pending slot
  always_comb
  begin
    create_en = '0;
    if (accept)
      create_en[trans_first ? alloc_ptr : pend_idx] = 1'b1;
  end

  // oldest entry drains its count, one response per step
  assign retire_en   = entry_vld[retire_ptr] && cmplt_x[retire_ptr];
  assign retire_last = retire_en && !cmplt_2[retire_ptr];
  assign resp_vld    = retire_en;

  always_comb
  begin
    inv_en = '0;
    inv_en[retire_ptr] = retire_en;
  end

  always_ff @(posedge ctcqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      alloc_ptr  <= '0;
      retire_ptr <= '0;
      pend_idx   <= '0;
    end
    else
    begin
      if (accept && trans_first)
      begin
        alloc_ptr <= next_idx(alloc_ptr);
        pend_idx  <= alloc_ptr;
      end
      // entry frees on this decrement
      if (retire_last)
        retire_ptr <= next_idx(retire_ptr);
    end
  end

endmodule

`default_nettype wire

// File: hw/ctcq_entry.sv
// ctcq queue entry
`timescale 1ns/1ns
`default_nettype none

module ctcq_entry (
  input  logic                                     ctcqctrlclk,
  input  logic                                     cpurst_b,
  input  logic                                     create_en,
  input  logic                                     trans_first,
  input  ctcq_pkg::ctcq_op_e                       create_op,
  input  logic [ctcq_pkg::CTCQ_ASID_WIDTH-1:0]     create_asid_va,
  input  logic [ctcq_pkg::CTCQ_VA_PA_WIDTH-1:0]    create_va_pa,
  input  logic                                     grant,
  input  logic                                     inv_cmplt,
  input  logic                                     inv_en,
  output logic                                     entry_vld,
  output logic                                     wait_2nd,
  output logic                                     pe_req,
  output logic                                     cmplt_x,
  output logic                                     cmplt_2,
  output ctcq_pkg::ctcq_op_e                       op,
  output logic [ctcq_pkg::CTCQ_ASID_WIDTH-1:0]     asid_va,
  output logic [ctcq_pkg::CTCQ_VA_PA_WIDTH-1:0]    va_pa
);

  import ctcq_pkg::*;

  //******************************
  // entry state
  //******************************
  // op needs a second transaction
  logic       need_2nd;
  // second transaction has arrived
  logic       vld_2nd;
  // granted and waiting on the engine
  logic       in_svc;
  // responses still owed
  logic [1:0] cmplt_cnt;

  logic       create_1st;
  logic       create_2nd;
  logic       entry_full;
  logic       take_cmplt;
  logic       entry_free;

  // first vs second create
  assign create_1st = create_en && trans_first;
  assign create_2nd = create_en && !trans_first;

  // all transactions of the op are in
  assign entry_full = entry_vld && (!need_2nd || vld_2nd);

  // only a valid entry in service with no count yet takes the broadcast completion
  assign take_cmplt = inv_cmplt && entry_vld && in_svc && (cmplt_cnt == 2'd0);

  // last response retires the entry
  assign entry_free = inv_en && (cmplt_cnt == 2'd1);

  // entry valid
  always_ff @(posedge ctcqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (create_1st)
      entry_vld <= 1'b1;
    else if (entry_free)
      entry_vld <= 1'b0;
  end

  // second transaction bookkeeping
  always_ff @(posedge ctcqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      need_2nd <= 1'b0;
      vld_2nd  <= 1'b0;
    end
    else if (create_1st)
    begin
      need_2nd <= ctcq_op_needs_2nd(create_op);
      vld_2nd  <= 1'b0;
    end
    else if (create_2nd)
      vld_2nd <= 1'b1;
  end

  // in service from grant until reuse
  always_ff @(posedge ctcqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      in_svc <= 1'b0;
    else if (create_1st)
      in_svc <= 1'b0;
    else if (grant)
      in_svc <= 1'b1;
  end

  // completion count of one per transaction
  always_ff @(posedge ctcqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cmplt_cnt <= 2'd0;
    else if (create_1st)
      cmplt_cnt <= 2'd0;
    else if (take_cmplt)
      cmplt_cnt <= need_2nd ? 2'd2 : 2'd1;
    else if (inv_en)
      cmplt_cnt <= cmplt_cnt - 2'd1;
  end

  //******************************
  // payload
  //******************************
  // type and asid/va come with the first transaction
  always_ff @(posedge ctcqctrlclk)
  begin
    if (create_1st)
    begin
      op      <= create_op;
      asid_va <= create_asid_va;
    end
  end

  // va/pa comes with the second
  always_ff @(posedge ctcqctrlclk)
  begin
    if (create_2nd)
      va_pa <= create_va_pa;
  end

  // outputs
  assign wait_2nd = entry_vld && need_2nd && !vld_2nd;
  assign pe_req   = entry_full && !in_svc;
  assign cmplt_x  = |cmplt_cnt;
  assign cmplt_2  = cmplt_cnt[1];

endmodule

`default_nettype wire

// File: hw/ctcq_inv_engine.sv
// ctcq invalidation engine
`timescale 1ns/1ns
`default_nettype none

module ctcq_inv_engine #(
  parameter int LINE_LAT = 2,
  parameter int ALL_LAT  = 6
) (
  input  logic                                      ctcqctrlclk,
  input  logic                                      cpurst_b,
  input  logic                                      start,
  input  ctcq_pkg::ctcq_op_e                        op,
  input  logic [ctcq_pkg::CTCQ_ASID_WIDTH-1:0]      asid_va,
  input  logic [ctcq_pkg::CTCQ_VA_PA_WIDTH-1:0]     va_pa,
  output logic                                      eng_idle,
  output logic                                      inv_cmplt,
  output logic                                      inv_vld,
  output ctcq_pkg::ctcq_op_e                        inv_op,
  output logic [ctcq_pkg::CTCQ_ASID_WIDTH-1:0]      inv_asid,
  output logic [ctcq_pkg::CTCQ_TLB_VA_WIDTH-1:0]    inv_va,
  output logic [ctcq_pkg::CTCQ_INDEX_WIDTH-1:0]     inv_index,
  output logic [ctcq_pkg::CTCQ_PTAG_WIDTH-1:0]      inv_ptag
);

  import ctcq_pkg::*;

  localparam int MAX_LAT = (LINE_LAT > ALL_LAT) ? LINE_LAT : ALL_LAT;
  localparam int CNT_W   = $clog2(MAX_LAT + 1);

  ctcq_eng_state_e  state;
  logic [CNT_W-1:0] lat_cnt;
  logic [CNT_W-1:0] lat_load;
  logic             eng_start;
  logic             is_tlb;
  logic             is_tlb_va;
  logic             is_line;

  //******************************
  // decode
  //******************************
  assign is_tlb    = (op == tlb_all) || (op == tlb_va_all) ||
                     (op == tlb_asid_all) || (op == tlb_va_asid);
  assign is_tlb_va = (op == tlb_va_all) || (op == tlb_va_asid);
  assign is_line   = (op == ic_line);

  // address ops are short, whole-structure ops long
  assign lat_load  = ctcq_op_needs_2nd(op) ? CNT_W'(LINE_LAT) : CNT_W'(ALL_LAT);

  assign eng_idle  = (state == st_idle);
  assign eng_start = start && eng_idle;

  // latch the invalidation, unused fields zeroed
  always_ff @(posedge ctcqctrlclk)
  begin
    if (eng_start)
    begin
      inv_op    <= op;
      inv_asid  <= is_tlb ? asid_va : '0;
      inv_va    <= is_tlb_va ? va_pa[CTCQ_VA_WIDTH-5:8] : '0;
      inv_index <= is_line ? va_pa[7:2] : '0;
      inv_ptag  <= is_line ? va_pa[CTCQ_PA_WIDTH-5:8] : '0;
    end
  end

  //******************************
  // latency FSM
  //******************************
  always_ff @(posedge ctcqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      state   <= st_idle;
      lat_cnt <= '0;
      inv_vld <= 1'b0;
    end
    else
    begin
      // one-cycle strobe with the latched fields
      inv_vld <= eng_start;
      case (state)
        st_idle:
          if (eng_start)
          begin
            state   <= st_busy;
            lat_cnt <= lat_load;
          end
        st_busy:
          if (lat_cnt == '0)
            state <= st_idle;
          else
            lat_cnt <= lat_cnt - 1'b1;
        default:
          state <= st_idle;
      endcase
    end
  end

  // done once the count runs out
  assign inv_cmplt = (state == st_busy) && (lat_cnt == '0);

endmodule

`default_nettype wire

// File: hw/ctcq_issue_arb.sv
// ctcq round-robin issue arbiter
`timescale 1ns/1ns
`default_nettype none

module ctcq_issue_arb #(
  parameter  int NUM_ENTRY = 4,
  localparam int IDX_W     = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1
) (
  input  logic                 ctcqctrlclk,
  input  logic                 cpurst_b,
  input  logic [NUM_ENTRY-1:0] pe_req,
  input  logic                 eng_idle,
  output logic [NUM_ENTRY-1:0] grant,
  output logic [IDX_W-1:0]     grant_idx
);

  //******************************
  // priority pointer
  //******************************
  // last granted entry, search starts after it
  logic [IDX_W-1:0] last_idx;
  logic             grant_any;

  // combinational pick, only with the engine idle
  always_comb
  begin
    int unsigned cand;
    logic        found;
    cand      = 0;
    found     = 1'b0;
    grant     = '0;
    grant_idx = '0;
    for (int i = 1; i <= NUM_ENTRY; i++)
    begin
      cand = (int'(last_idx) + i) % NUM_ENTRY;
      if (!found && pe_req[cand])
      begin
        found     = 1'b1;
        grant_idx = IDX_W'(cand);
      end
    end
    if (found && eng_idle)
      grant[grant_idx] = 1'b1;
  end

  assign grant_any = |grant;

  // move priority past each winner
  always_ff @(posedge ctcqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      // entry 0 first out of reset
      last_idx <= IDX_W'(NUM_ENTRY - 1);
    else if (grant_any)
      last_idx <= grant_idx;
  end

endmodule

`default_nettype wire

// File: hw/ctcq_pkg.sv
// ctcq shared definitions
`default_nettype none

package ctcq_pkg;

  //******************************
  // widths
  //******************************
  localparam int CTCQ_PA_WIDTH   = 40;
  localparam int CTCQ_VA_WIDTH   = 39;
  localparam int CTCQ_ASID_WIDTH = 16;
  // stored va/pa drops the low 4 bits of the pa
  localparam int CTCQ_VA_PA_WIDTH = CTCQ_PA_WIDTH - 4;
  // fields decoded from va/pa, all start at bit 8
  localparam int CTCQ_TLB_VA_WIDTH = CTCQ_VA_WIDTH - 12;
  localparam int CTCQ_PTAG_WIDTH   = CTCQ_PA_WIDTH - 12;
  localparam int CTCQ_INDEX_WIDTH  = 6;

  // default engine latencies in cycles
  localparam int CTCQ_LINE_LAT = 2;
  localparam int CTCQ_ALL_LAT  = 6;

  //******************************
  // operation and engine types
  //******************************
  // bit 3 splits tlb and icache, bit 0 flags a second transaction
  typedef enum logic [3:0] {
    tlb_all      = 4'b0000,
    tlb_va_all   = 4'b0001,
    tlb_asid_all = 4'b0010,
    tlb_va_asid  = 4'b0011,
    ic_all       = 4'b1000,
    ic_line      = 4'b1001
  } ctcq_op_e;

  typedef enum logic {
    st_idle,
    st_busy
  } ctcq_eng_state_e;

  // ops carrying an address come in two transactions
  function automatic logic ctcq_op_needs_2nd(input ctcq_op_e op);
    return (op == tlb_va_all) || (op == tlb_va_asid) || (op == ic_line);
  endfunction

endpackage

`default_nettype wire

// File: hw/ctcq_top.sv
// ctcq maintenance queue top
`timescale 1ns/1ns
`default_nettype none

module ctcq_top #(
  parameter  int NUM_ENTRY = 4,
  parameter  int LINE_LAT  = ctcq_pkg::CTCQ_LINE_LAT,
  parameter  int ALL_LAT   = ctcq_pkg::CTCQ_ALL_LAT,
  localparam int IDX_W     = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1
) (
  input  logic                                      ctcqctrlclk,
  input  logic                                      cpurst_b,
  input  logic                                      trans_vld,
  input  logic                                      trans_first,
  input  ctcq_pkg::ctcq_op_e                        trans_op,
  input  logic [ctcq_pkg::CTCQ_ASID_WIDTH-1:0]      trans_asid_va,
  input  logic [ctcq_pkg::CTCQ_VA_PA_WIDTH-1:0]     trans_va_pa,
  output logic                                      trans_rdy,
  output logic                                      inv_vld,
  output ctcq_pkg::ctcq_op_e                        inv_op,
  output logic [ctcq_pkg::CTCQ_ASID_WIDTH-1:0]      inv_asid,
  output logic [ctcq_pkg::CTCQ_TLB_VA_WIDTH-1:0]    inv_va,
  output logic [ctcq_pkg::CTCQ_INDEX_WIDTH-1:0]     inv_index,
  output logic [ctcq_pkg::CTCQ_PTAG_WIDTH-1:0]      inv_ptag,
  output logic                                      resp_vld
);

  import ctcq_pkg::*;

  //******************************
  // per-entry wires
  //******************************
  logic [NUM_ENTRY-1:0]        create_en;
  logic [NUM_ENTRY-1:0]        grant;
  logic [NUM_ENTRY-1:0]        inv_en;
  logic [NUM_ENTRY-1:0]        entry_vld;
  logic [NUM_ENTRY-1:0]        wait_2nd;
  logic [NUM_ENTRY-1:0]        pe_req;
  logic [NUM_ENTRY-1:0]        cmplt_x;
  logic [NUM_ENTRY-1:0]        cmplt_2;
  ctcq_op_e                    ent_op      [NUM_ENTRY];
  logic [CTCQ_ASID_WIDTH-1:0]  ent_asid_va [NUM_ENTRY];
  logic [CTCQ_VA_PA_WIDTH-1:0] ent_va_pa   [NUM_ENTRY];

  logic [IDX_W-1:0]            grant_idx;
  logic                        eng_idle;
  logic                        inv_cmplt;

  // the queue
  for (genvar i = 0; i < NUM_ENTRY; i++)
  begin : gen_entry
    // completion goes to every entry, only the one in service takes it
    ctcq_entry u_entry (
      .ctcqctrlclk    (ctcqctrlclk),
      .cpurst_b       (cpurst_b),
      .create_en      (create_en[i]),
      .trans_first    (trans_first),
      .create_op      (trans_op),
      .create_asid_va (trans_asid_va),
      .create_va_pa   (trans_va_pa),
      .grant          (grant[i]),
      .inv_cmplt      (inv_cmplt),
      .inv_en         (inv_en[i]),
      .entry_vld      (entry_vld[i]),
      .wait_2nd       (wait_2nd[i]),
      .pe_req         (pe_req[i]),
      .cmplt_x        (cmplt_x[i]),
      .cmplt_2        (cmplt_2[i]),
      .op             (ent_op[i]),
      .asid_va        (ent_asid_va[i]),
      .va_pa          (ent_va_pa[i])
    );
  end

  // allocation, steering, retire
  ctcq_create_ctrl #(
    .NUM_ENTRY (NUM_ENTRY)
  ) u_create_ctrl (
    .ctcqctrlclk (ctcqctrlclk),
    .cpurst_b    (cpurst_b),
    .trans_vld   (trans_vld),
    .trans_first (trans_first),
    .entry_vld   (entry_vld),
    .wait_2nd    (wait_2nd),
    .cmplt_x     (cmplt_x),
    .cmplt_2     (cmplt_2),
    .trans_rdy   (trans_rdy),
    .create_en   (create_en),
    .inv_en      (inv_en),
    .resp_vld    (resp_vld)
  );

  ctcq_issue_arb #(
    .NUM_ENTRY (NUM_ENTRY)
  ) u_issue_arb (
    .ctcqctrlclk (ctcqctrlclk),
    .cpurst_b    (cpurst_b),
    .pe_req      (pe_req),
    .eng_idle    (eng_idle),
    .grant       (grant),
    .grant_idx   (grant_idx)
  );

  // granted entry's fields into the engine
  ctcq_inv_engine #(
    .LINE_LAT (LINE_LAT),
    .ALL_LAT  (ALL_LAT)
  ) u_inv_engine (
    .ctcqctrlclk (ctcqctrlclk),
    .cpurst_b    (cpurst_b),
    .start       (|grant),
    .op          (ent_op[grant_idx]),
    .asid_va     (ent_asid_va[grant_idx]),
    .va_pa       (ent_va_pa[grant_idx]),
    .eng_idle    (eng_idle),
    .inv_cmplt   (inv_cmplt),
    .inv_vld     (inv_vld),
    .inv_op      (inv_op),
    .inv_asid    (inv_asid),
    .inv_va      (inv_va),
    .inv_index   (inv_index),
    .inv_ptag    (inv_ptag)
  );

endmodule

`default_nettype wire

// File: sim/ctcq_checker.sv
// ctcq invalidation and response checker
`timescale 1ns/1ns
`default_nettype none

module ctcq_checker (
  input  logic                                      ctcqctrlclk,
  input  logic                                      cpurst_b,
  input  logic                                      trans_rdy,
  input  logic                                      inv_vld,
  input  ctcq_pkg::ctcq_op_e                        inv_op,
  input  logic [ctcq_pkg::CTCQ_ASID_WIDTH-1:0]      inv_asid,
  input  logic [ctcq_pkg::CTCQ_TLB_VA_WIDTH-1:0]    inv_va,
  input  logic [ctcq_pkg::CTCQ_INDEX_WIDTH-1:0]     inv_index,
  input  logic [ctcq_pkg::CTCQ_PTAG_WIDTH-1:0]      inv_ptag,
  input  logic                                      resp_vld,
  output int                                        err_count,
  output int                                        pend_inv,
  output int                                        owed_resp
);

  import ctcq_pkg::*;

  // record layout: op, asid, va, index, ptag
  localparam int REC_W = $bits(ctcq_op_e) + CTCQ_ASID_WIDTH + CTCQ_TLB_VA_WIDTH +
                         CTCQ_INDEX_WIDTH + CTCQ_PTAG_WIDTH;

  //******************************
  // scoreboard state
  //******************************
  logic [REC_W-1:0] exp_q [$];
  int               inv_exp;
  int               inv_seen;
  int               resp_exp;
  int               resp_seen;
  logic             rdy_checked;
  logic [REC_W-1:0] seen_rec;

  initial
  begin
    err_count   = 0;
    pend_inv    = 0;
    owed_resp   = 0;
    inv_exp     = 0;
    inv_seen    = 0;
    resp_exp    = 0;
    resp_seen   = 0;
    rdy_checked = 1'b0;
  end

  assign seen_rec = {inv_op, inv_asid, inv_va, inv_index, inv_ptag};

  // called by the testbench once an op is fully accepted
  task automatic add_expect(input logic [REC_W-1:0] rec, input int n_trans);
    exp_q.push_back(rec);
    inv_exp++;
    resp_exp += n_trans;
    pend_inv  = exp_q.size();
    owed_resp = resp_exp - resp_seen;
  endtask

  // any outstanding record may match, then it is consumed
  task automatic match_inv(input logic [REC_W-1:0] rec);
    int hit;
    hit = -1;
    foreach (exp_q[i])
      if (hit < 0 && exp_q[i] == rec)
        hit = i;
    if (hit < 0)
    begin
      err_count++;
      $display("MISMATCH %0t: invalidation op=%s asid=%h va=%h index=%h ptag=%h unexpected",
               $time, inv_op.name(), inv_asid, inv_va, inv_index, inv_ptag);
    end
    else
      exp_q.delete(hit);
    pend_inv = exp_q.size();
  endtask

  //******************************
  // sampling at the falling edge
  //******************************
  always @(negedge ctcqctrlclk)
  begin
    if (cpurst_b)
    begin
      // first cycle out of reset
      if (!rdy_checked)
      begin
        rdy_checked = 1'b1;
        if (trans_rdy !== 1'b1)
        begin
          err_count++;
          $display("MISMATCH %0t: trans_rdy is %b after reset, expected 1", $time, trans_rdy);
        end
      end
      if ($isunknown(inv_vld) || $isunknown(resp_vld))
      begin
        err_count++;
        $display("inv_vld or resp_vld is unknown at time %0t", $time);
      end
      if (inv_vld === 1'b1)
      begin
        inv_seen++;
        match_inv(seen_rec);
      end
      if (resp_vld === 1'b1)
      begin
        resp_seen++;
        if (resp_seen > resp_exp)
        begin
          err_count++;
          $display("MISMATCH %0t: resp_vld pulse %0d with only %0d expected",
                   $time, resp_seen, resp_exp);
        end
        owed_resp = resp_exp - resp_seen;
      end
    end
  end

  // leftovers and totals at the end of the run
  task automatic final_report();
    foreach (exp_q[i])
    begin
      err_count++;
      $display("expected invalidation was never issued, record %h", exp_q[i]);
    end
    if (inv_seen != inv_exp)
    begin
      err_count++;
      $display("MISMATCH %0t: %0d invalidations seen, %0d expected", $time, inv_seen, inv_exp);
    end
    if (resp_seen != resp_exp)
    begin
      err_count++;
      $display("MISMATCH %0t: %0d responses seen, %0d expected", $time, resp_seen, resp_exp);
    end
  endtask

endmodule

`default_nettype wire

// File: sim/ctcq_tb.sv
// ctcq testbench top
`timescale 1ns/1ns
`default_nettype none

module ctcq_tb;

  import ctcq_pkg::*;

  localparam int NUM_ENTRY     = 4;
  localparam int LINE_LAT      = 2;
  localparam int ALL_LAT       = 6;
  localparam int REC_W         = $bits(ctcq_op_e) + CTCQ_ASID_WIDTH + CTCQ_TLB_VA_WIDTH +
                                 CTCQ_INDEX_WIDTH + CTCQ_PTAG_WIDTH;
  localparam int RDY_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 1000;
  localparam int NUM_RAND      = 60;

  logic                         ctcqctrlclk;
  logic                         cpurst_b;
  logic                         trans_vld;
  logic                         trans_first;
  ctcq_op_e                     trans_op;
  logic [CTCQ_ASID_WIDTH-1:0]   trans_asid_va;
  logic [CTCQ_VA_PA_WIDTH-1:0]  trans_va_pa;
  logic                         trans_rdy;
  logic                         inv_vld;
  ctcq_op_e                     inv_op;
  logic [CTCQ_ASID_WIDTH-1:0]   inv_asid;
  logic [CTCQ_TLB_VA_WIDTH-1:0] inv_va;
  logic [CTCQ_INDEX_WIDTH-1:0]  inv_index;
  logic [CTCQ_PTAG_WIDTH-1:0]   inv_ptag;
  logic                         resp_vld;
  int                           err_count;
  int                           pend_inv;
  int                           owed_resp;
  int                           tb_errs;
  logic                         rdy_low_seen;
  ctcq_op_e                     op_list [6];

  always #4 ctcqctrlclk = ~ctcqctrlclk;

  ctcq_top #(
    .NUM_ENTRY (NUM_ENTRY),
    .LINE_LAT  (LINE_LAT),
    .ALL_LAT   (ALL_LAT)
  ) ctcq_top_i (
    .ctcqctrlclk   (ctcqctrlclk),
    .cpurst_b      (cpurst_b),
    .trans_vld     (trans_vld),
    .trans_first   (trans_first),
    .trans_op      (trans_op),
    .trans_asid_va (trans_asid_va),
    .trans_va_pa   (trans_va_pa),
    .trans_rdy     (trans_rdy),
    .inv_vld       (inv_vld),
    .inv_op        (inv_op),
    .inv_asid      (inv_asid),
    .inv_va        (inv_va),
    .inv_index     (inv_index),
    .inv_ptag      (inv_ptag),
    .resp_vld      (resp_vld)
  );

  ctcq_checker chk_i (
    .ctcqctrlclk (ctcqctrlclk),
    .cpurst_b    (cpurst_b),
    .trans_rdy   (trans_rdy),
    .inv_vld     (inv_vld),
    .inv_op      (inv_op),
    .inv_asid    (inv_asid),
    .inv_va      (inv_va),
    .inv_index   (inv_index),
    .inv_ptag    (inv_ptag),
    .resp_vld    (resp_vld),
    .err_count   (err_count),
    .pend_inv    (pend_inv),
    .owed_resp   (owed_resp)
  );

  //******************************
  // reference model
  //******************************
  // address ops arrive as two transactions
  function automatic int trans_count(input ctcq_op_e op);
    case (op)
      tlb_va_all, tlb_va_asid, ic_line: return 2;
      default:                          return 1;
    endcase
  endfunction

  // expected invalidation with fields unused by the op left zero
  function automatic logic [REC_W-1:0] expect_inv(input ctcq_op_e op,
                                                  input logic [CTCQ_ASID_WIDTH-1:0] asid_va,
                                                  input logic [CTCQ_VA_PA_WIDTH-1:0] va_pa);
    logic [CTCQ_ASID_WIDTH-1:0]   asid;
    logic [CTCQ_TLB_VA_WIDTH-1:0] va;
    logic [CTCQ_INDEX_WIDTH-1:0]  index;
    logic [CTCQ_PTAG_WIDTH-1:0]   ptag;
    asid  = '0;
    va    = '0;
    index = '0;
    ptag  = '0;
    // every tlb op carries the asid field
    if (op == tlb_all || op == tlb_asid_all || op == tlb_va_all || op == tlb_va_asid)
      asid = asid_va;
    if (op == tlb_va_all || op == tlb_va_asid)
      va = va_pa[8 +: CTCQ_TLB_VA_WIDTH];
    if (op == ic_line)
    begin
      index = va_pa[7:2];
      ptag  = va_pa[8 +: CTCQ_PTAG_WIDTH];
    end
    return {op, asid, va, index, ptag};
  endfunction

  //******************************
  // stimulus
  //******************************
  // random field values at the port widths
  function automatic logic [CTCQ_ASID_WIDTH-1:0] rand_asid();
    return CTCQ_ASID_WIDTH'($urandom);
  endfunction

  function automatic logic [CTCQ_VA_PA_WIDTH-1:0] rand_va_pa();
    return CTCQ_VA_PA_WIDTH'({$urandom, $urandom});
  endfunction

  // hold the strobe until trans_rdy is seen at the falling edge
  task automatic send_trans(input logic first, input ctcq_op_e op,
                            input logic [CTCQ_ASID_WIDTH-1:0] asid_va,
                            input logic [CTCQ_VA_PA_WIDTH-1:0] va_pa);
    int   waited;
    logic accepted;
    waited        = 0;
    accepted      = 1'b0;
    trans_vld     = 1'b1;
    trans_first   = first;
    trans_op      = op;
    trans_asid_va = asid_va;
    trans_va_pa   = va_pa;
    while (!accepted && waited < RDY_TIMEOUT)
    begin
      @(negedge ctcqctrlclk);
      if (trans_rdy)
        accepted = 1'b1;
      else
      begin
        rdy_low_seen = 1'b1;
        waited++;
      end
      @(posedge ctcqctrlclk);
      #1;
    end
    trans_vld = 1'b0;
    if (!accepted)
    begin
      tb_errs++;
      $display("timeout: transaction of op %s was never accepted", op.name());
    end
  endtask

  // whole op with junk in the fields the DUT must ignore
  task automatic send_op(input ctcq_op_e op, input logic [CTCQ_ASID_WIDTH-1:0] asid_va,
                         input logic [CTCQ_VA_PA_WIDTH-1:0] va_pa);
    logic [CTCQ_ASID_WIDTH-1:0]  junk_asid;
    logic [CTCQ_VA_PA_WIDTH-1:0] junk_pa;
    junk_asid = rand_asid();
    junk_pa   = rand_va_pa();
    send_trans(1'b1, op, asid_va, junk_pa);
    if (trans_count(op) == 2)
      send_trans(1'b0, op, junk_asid, va_pa);
    chk_i.add_expect(expect_inv(op, asid_va, va_pa), trans_count(op));
  endtask

  // wait for every invalidation and response
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((pend_inv != 0 || owed_resp != 0) && waited < DRAIN_TIMEOUT)
    begin
      @(posedge ctcqctrlclk);
      #1;
      waited++;
    end
    if (pend_inv != 0 || owed_resp != 0)
    begin
      tb_errs++;
      $display("timeout: queue did not drain, %0d invalidations and %0d responses missing",
               pend_inv, owed_resp);
    end
  endtask

  initial
  begin
    int gap;
    void'($urandom(32'hb4e10e29));
    op_list[0]    = tlb_all;
    op_list[1]    = tlb_va_all;
    op_list[2]    = tlb_asid_all;
    op_list[3]    = tlb_va_asid;
    op_list[4]    = ic_all;
    op_list[5]    = ic_line;
    ctcqctrlclk   = 1'b0;
    cpurst_b      = 1'b0;
    trans_vld     = 1'b0;
    trans_first   = 1'b1;
    trans_op      = tlb_all;
    trans_asid_va = '0;
    trans_va_pa   = '0;
    tb_errs       = 0;
    rdy_low_seen  = 1'b0;
    repeat (5) @(posedge ctcqctrlclk);
    #1;
    cpurst_b = 1'b1;

    // quiet after reset so any pulse is flagged
    repeat (10) @(posedge ctcqctrlclk);
    #1;

    // each op type alone
    foreach (op_list[i])
    begin
      send_op(op_list[i], rand_asid(), rand_va_pa());
      wait_drain();
    end

    // one more slow op than entries so the last one waits
    rdy_low_seen = 1'b0;
    for (int i = 0; i <= NUM_ENTRY; i++)
      send_op((i % 2) ? ic_all : tlb_all, rand_asid(), rand_va_pa());
    if (!rdy_low_seen)
    begin
      tb_errs++;
      $display("trans_rdy never dropped while all %0d entries were full", NUM_ENTRY);
    end
    wait_drain();

    // random mix
    for (int n = 0; n < NUM_RAND; n++)
    begin
      send_op(op_list[$urandom % 6], rand_asid(), rand_va_pa());
      gap = $urandom % 3;
      repeat (gap)
      begin
        @(posedge ctcqctrlclk);
        #1;
      end
    end
    wait_drain();

    chk_i.final_report();
    $display("errors: %0d total, %0d from checker, %0d from testbench",
             err_count + tb_errs, err_count, tb_errs);
    if (err_count + tb_errs == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
